/* Bender.yml */
package:
  name: mem_system

export_include_dirs:
  - hw

sources:
  # Packages first, then the RTL bottom up
  - hw/cache_pkg.sv
  - hw/mem_pkg.sv
  - hw/cache_array.sv
  - hw/cache_ctrl.sv
  - hw/mem_arbiter.sv
  - hw/banked_mem.sv
  - hw/mem_system.sv
  - target: test
    files:
      - verif/tb_clkgen.sv
      - verif/tb_mem_system.sv

/* hw/banked_mem.sv */
// Four bank interleaved memory
`default_nettype none
`timescale 1ns/1ps

`include "mem_system_consts.svh"

module banked_mem
   import mem_pkg::*;
(
   input  logic     clk,
   input  logic     arst_n,
   input  mem_req_t req,
   output mem_rsp_t rsp
);

   // Bank from word bits, row from the rest
   logic [`MS_OFFSET_W-2:0]            bank_sel;
   logic [`MS_ADDR_W-`MS_OFFSET_W-1:0] row;

   // Registered bank outputs, first stage
   logic [`MS_DATA_W-1:0] bank_rdata [`MS_LINE_WORDS];
   logic [`MS_OFFSET_W-2:0] sel_s1;

   // Second stage
   logic [`MS_DATA_W-1:0] rdata_s2;
   logic [`MS_MEM_LAT-1:0] vld_pipe;

   assign bank_sel = req.addr[`MS_OFFSET_W-1:1];
   assign row      = req.addr[`MS_ADDR_W-1:`MS_OFFSET_W];

   //////////////////////////////////////////////////
   // Banks
   //////////////////////////////////////////////////

   for (genvar b = 0; b < `MS_LINE_WORDS; b++) begin : g_bank
      localparam logic [`MS_OFFSET_W-2:0] BANK = b;

      logic [`MS_DATA_W-1:0] mem [2**(`MS_ADDR_W-`MS_OFFSET_W)];
      logic [`MS_DATA_W-1:0] rdata_q;

      // Write at the beat edge, read registered
      always_ff @(posedge clk) begin
         if (req.valid && (bank_sel == BANK)) begin
            if (req.op == MEM_WRITE) begin
               mem[row] <= req.wdata;
            end else begin
               rdata_q <= mem[row];
            end
         end
      end

      assign bank_rdata[b] = rdata_q;
   end

   //////////////////////////////////////////////////
   // Read pipeline
   //////////////////////////////////////////////////

   // Valid tracks read beats only
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         vld_pipe <= '0;
      end else begin
         vld_pipe <= {vld_pipe[`MS_MEM_LAT-2:0], req.valid && (req.op == MEM_READ)};
      end
   end

   // Pick the bank that took the beat one cycle back
   always_ff @(posedge clk) begin
      sel_s1   <= bank_sel;
      rdata_s2 <= bank_rdata[sel_s1];
   end

   assign rsp = '{valid: vld_pipe[`MS_MEM_LAT-1], rdata: rdata_s2};

endmodule

`default_nettype wire

/* hw/cache_array.sv */
// Direct-mapped cache storage
`default_nettype none
`timescale 1ns/1ps

`include "mem_system_consts.svh"

module cache_array
   import cache_pkg::*;
(
   input  logic      clk,
   input  logic      arst_n,
   input  logic      en,
   input  logic      we,
   input  index_t    index,
   input  word_sel_t word_sel,
   input  tag_t      tag_in,
   input  word_t     wdata,
   input  logic      set_valid,
   input  logic      set_dirty,
   output tag_t      tag_out,
   output logic      valid,
   output logic      dirty,
   output word_t     rdata
);

   // State bits, one per line
   logic [2**`MS_INDEX_W-1:0] valid_bits;
   logic [2**`MS_INDEX_W-1:0] dirty_bits;

   // Tag per line, data per word
   tag_t  tag_mem  [2**`MS_INDEX_W];
   word_t data_mem [2**(`MS_INDEX_W+`MS_OFFSET_W-1)];

   //////////////////////////////////////////////////
   // Line state
   //////////////////////////////////////////////////

   // Read gives the old state, write lands at the same edge
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_bits <= '0;
         dirty_bits <= '0;
         valid      <= 1'b0;
         dirty      <= 1'b0;
      end else if (en) begin
         valid <= valid_bits[index];
         dirty <= dirty_bits[index];
         // Fill beat, line becomes valid with given dirty state
         if (we && set_valid) begin
            valid_bits[index] <= 1'b1;
            dirty_bits[index] <= set_dirty;
         end else if (we && set_dirty) begin
            // Processor write into a resident line
            dirty_bits[index] <= 1'b1;
         end
      end
   end

   //////////////////////////////////////////////////
   // Tag and data
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (en) begin
         tag_out <= tag_mem[index];
         rdata   <= data_mem[{index, word_sel}];
         if (we) begin
            data_mem[{index, word_sel}] <= wdata;
         end
         // Tag only changes on a fill
         if (we && set_valid) begin
            tag_mem[index] <= tag_in;
         end
      end
   end

endmodule

`default_nettype wire

/* hw/cache_ctrl.sv */
// Write-back cache controller
`default_nettype none
`timescale 1ns/1ps

`include "mem_system_consts.svh"

module cache_ctrl
   import cache_pkg::*;
   import mem_pkg::*;
(
   input  logic     clk,
   input  logic     arst_n,
   input  cpu_req_t req,
   output cpu_rsp_t rsp,
   output logic     err,
   output logic     bus_want,
   input  logic     bus_grant,
   output mem_req_t mem_req,
   input  mem_rsp_t mem_rsp
);

   cache_state_e state_q;

   // Latched request
   logic [`MS_ADDR_W-1:0] addr_q;
   word_t                 wdata_q;
   logic                  wr_q;
   logic                  hit_q;

   // Issued beats, runs to LINE_WORDS in FILL
   logic [`MS_OFFSET_W-1:0] beat_q;
   // Fill responses received
   word_sel_t               rsp_cnt_q;

   // Address fields, live request and latched request
   index_t    in_index;
   word_sel_t in_word;
   tag_t      req_tag;
   index_t    req_index;
   word_sel_t req_word;

   logic accept;
   logic lookup_hit;
   logic victim_dirty;
   logic fill_issue;
   logic rsp_take;

   // Array port
   logic      arr_en;
   logic      arr_we;
   word_sel_t arr_word;
   word_t     arr_wdata;
   logic      arr_set_valid;
   logic      arr_set_dirty;
   index_t    arr_index;
   tag_t      arr_tag;
   logic      arr_valid;
   logic      arr_dirty;
   word_t     arr_rdata;

   assign in_index  = req.addr[`MS_OFFSET_W +: `MS_INDEX_W];
   assign in_word   = req.addr[`MS_OFFSET_W-1:1];
   assign req_tag   = addr_q[`MS_ADDR_W-1 -: `MS_TAG_W];
   assign req_index = addr_q[`MS_OFFSET_W +: `MS_INDEX_W];
   assign req_word  = addr_q[`MS_OFFSET_W-1:1];

   // Only a single rd or wr strobe in IDLE is taken
   assign accept = (state_q == IDLE) && (req.rd ^ req.wr);

   // Array outputs are valid in LOOKUP
   assign lookup_hit   = arr_valid && (arr_tag == req_tag);
   assign victim_dirty = arr_valid && arr_dirty;

   // Read beats go out while granted until the whole line is asked for
   assign fill_issue = (state_q == FILL) && bus_grant && (beat_q < `MS_LINE_WORDS);
   assign rsp_take   = (state_q == FILL) && bus_grant && mem_rsp.valid;

   cache_array u_array (
      .clk       (clk),
      .arst_n    (arst_n),
      .en        (arr_en),
      .we        (arr_we),
      .index     (arr_index),
      .word_sel  (arr_word),
      .tag_in    (req_tag),
      .wdata     (arr_wdata),
      .set_valid (arr_set_valid),
      .set_dirty (arr_set_dirty),
      .tag_out   (arr_tag),
      .valid     (arr_valid),
      .dirty     (arr_dirty),
      .rdata     (arr_rdata)
   );

   //////////////////////////////////////////////////
   // Array and bus control
   //////////////////////////////////////////////////

   always_comb begin
      arr_en        = 1'b0;
      arr_we        = 1'b0;
      arr_index     = req_index;
      arr_word      = req_word;
      arr_wdata     = wdata_q;
      arr_set_valid = 1'b0;
      arr_set_dirty = 1'b0;
      mem_req       = '0;
      case (state_q)
         IDLE: begin
            // Lookup read straight from the strobe
            arr_en    = accept;
            arr_index = in_index;
            arr_word  = in_word;
         end
         LOOKUP: begin
            if (lookup_hit && wr_q) begin
               arr_en        = 1'b1;
               arr_we        = 1'b1;
               arr_set_dirty = 1'b1;
            end else if (!lookup_hit && victim_dirty) begin
               // Preload first victim word
               arr_en   = 1'b1;
               arr_word = '0;
            end
         end
         WRITEBACK: begin
            if (bus_grant) begin
               // Victim tag still sits on tag_out, index is unchanged
               mem_req.valid = 1'b1;
               mem_req.op    = MEM_WRITE;
               mem_req.addr  = {arr_tag, req_index, beat_q[`MS_OFFSET_W-2:0], 1'b0};
               mem_req.wdata = arr_rdata;
               // Next victim word, one cycle ahead
               arr_en   = 1'b1;
               arr_word = beat_q[`MS_OFFSET_W-2:0] + 1'b1;
            end
         end
         FILL: begin
            if (fill_issue) begin
               mem_req.valid = 1'b1;
               mem_req.op    = MEM_READ;
               mem_req.addr  = {req_tag, req_index, beat_q[`MS_OFFSET_W-2:0], 1'b0};
            end
            // Responses come back in beat order
            if (rsp_take) begin
               arr_en        = 1'b1;
               arr_we        = 1'b1;
               arr_word      = rsp_cnt_q;
               arr_wdata     = mem_rsp.rdata;
               arr_set_valid = 1'b1;
            end
         end
         MISS_FINISH: begin
            // Apply the original access to the new line
            arr_en        = 1'b1;
            arr_we        = wr_q;
            arr_set_dirty = wr_q;
         end
         default: begin
         end
      endcase
   end

   //////////////////////////////////////////////////
   // FSM
   //////////////////////////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state_q   <= IDLE;
         hit_q     <= 1'b0;
         bus_want  <= 1'b0;
         beat_q    <= '0;
         rsp_cnt_q <= '0;
      end else begin
         case (state_q)
            IDLE: begin
               if (accept) begin
                  state_q <= LOOKUP;
               end
            end
            LOOKUP: begin
               hit_q     <= lookup_hit;
               beat_q    <= '0;
               rsp_cnt_q <= '0;
               if (lookup_hit) begin
                  state_q <= HIT_RETURN;
               end else begin
                  bus_want <= 1'b1;
                  state_q  <= victim_dirty ? WRITEBACK : FILL;
               end
            end
            WRITEBACK: begin
               if (bus_grant) begin
                  if (beat_q == `MS_LINE_WORDS - 1) begin
                     beat_q  <= '0;
                     state_q <= FILL;
                  end else begin
                     beat_q <= beat_q + 1'b1;
                  end
               end
            end
            FILL: begin
               if (fill_issue) begin
                  beat_q <= beat_q + 1'b1;
               end
               if (rsp_take) begin
                  rsp_cnt_q <= rsp_cnt_q + 1'b1;
                  // Last response in, release the bus
                  if (rsp_cnt_q == word_sel_t'(`MS_LINE_WORDS - 1)) begin
                     bus_want <= 1'b0;
                     state_q  <= MISS_FINISH;
                  end
               end
            end
            // Shared response cycle, hit_q tells which path
            MISS_FINISH: state_q <= HIT_RETURN;
            HIT_RETURN:  state_q <= IDLE;
            default:     state_q <= IDLE;
         endcase
      end
   end

   // Request payload
   always_ff @(posedge clk) begin
      if (accept) begin
         addr_q  <= req.addr;
         wdata_q <= req.wdata;
         wr_q    <= req.wr;
      end
   end

   // Bad strobe, both rd and wr or while busy
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         err <= 1'b0;
      end else begin
         err <= (req.rd || req.wr) && ((state_q != IDLE) || (req.rd && req.wr));
      end
   end

   // Processor response
   assign rsp.done  = (state_q == HIT_RETURN);
   assign rsp.stall = (state_q != IDLE);
   assign rsp.hit   = (state_q == HIT_RETURN) && hit_q;
   assign rsp.rdata = arr_rdata;

endmodule

`default_nettype wire

/* hw/cache_pkg.sv */
// Cache processor side types
`default_nettype none

`include "mem_system_consts.svh"

package cache_pkg;

   // Address fields and data word
   typedef logic [`MS_TAG_W-1:0]      tag_t;
   typedef logic [`MS_INDEX_W-1:0]    index_t;
   typedef logic [`MS_OFFSET_W-2:0]   word_sel_t;
   typedef logic [`MS_DATA_W-1:0]     word_t;

   // Processor request, one cycle strobe
   typedef struct packed {
      logic                  rd;
      logic                  wr;
      logic [`MS_ADDR_W-1:0] addr;
      word_t                 wdata;
   } cpu_req_t;

   // Processor response
   typedef struct packed {
      logic  done;
      logic  stall;
      logic  hit;
      word_t rdata;
   } cpu_rsp_t;

   // Controller FSM states
   typedef enum logic [2:0] {
      IDLE,
      LOOKUP,
      HIT_RETURN,
      WRITEBACK,
      FILL,
      MISS_FINISH
   } cache_state_e;

endpackage

`default_nettype wire

/* hw/mem_arbiter.sv */
// Round-robin memory bus arbiter
`default_nettype none
`timescale 1ns/1ps

module mem_arbiter
   import mem_pkg::*;
(
   input  logic     clk,
   input  logic     arst_n,
   input  logic     want_a,
   input  logic     want_b,
   output logic     grant_a,
   output logic     grant_b,
   input  mem_req_t req_a,
   input  mem_req_t req_b,
   output mem_req_t bus_req
);

   // Port b owned the bus last
   logic last_b;
   logic next_a;
   logic next_b;

   // Owner keeps the bus for as long as it wants it
   always_comb begin
      next_a = grant_a && want_a;
      next_b = grant_b && want_b;
      if (!next_a && !next_b) begin
         // Free bus goes to the port not served last
         if (want_a && (!want_b || last_b)) begin
            next_a = 1'b1;
         end else if (want_b) begin
            next_b = 1'b1;
         end
      end
   end

   // Out of reset b counts as last, so a wins a tie
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         grant_a <= 1'b0;
         grant_b <= 1'b0;
         last_b  <= 1'b1;
      end else begin
         grant_a <= next_a;
         grant_b <= next_b;
         if (next_a) begin
            last_b <= 1'b0;
         end else if (next_b) begin
            last_b <= 1'b1;
         end
      end
   end

   // Only the owner reaches memory
   always_comb begin
      bus_req = '0;
      if (grant_a) begin
         bus_req = req_a;
      end else if (grant_b) begin
         bus_req = req_b;
      end
   end

endmodule

`default_nettype wire

/* hw/mem_pkg.sv */
// Memory bus types
`default_nettype none

`include "mem_system_consts.svh"

package mem_pkg;

   // Beat opcode
   typedef enum logic {
      MEM_READ,
      MEM_WRITE
   } mem_op_e;

   // One bus beat, driven by the granted cache
   typedef struct packed {
      logic                  valid;
      mem_op_e               op;
      logic [`MS_ADDR_W-1:0] addr;
      logic [`MS_DATA_W-1:0] wdata;
   } mem_req_t;

   // Read data, fixed latency after the beat
   typedef struct packed {
      logic                  valid;
      logic [`MS_DATA_W-1:0] rdata;
   } mem_rsp_t;

endpackage

`default_nettype wire

/* hw/mem_system.sv */
// Two-port cached memory system
`default_nettype none
`timescale 1ns/1ps

module mem_system
   import cache_pkg::*;
   import mem_pkg::*;
(
   input  logic     clk,
   input  logic     arst_n,
   input  cpu_req_t inst_req,
   input  cpu_req_t data_req,
   output cpu_rsp_t inst_rsp,
   output cpu_rsp_t data_rsp,
   output logic     err
);

   // Per-port error pulses
   logic inst_err;
   logic data_err;

   // Arbitration, data port on side a
   logic inst_want;
   logic data_want;
   logic inst_grant;
   logic data_grant;

   // Bus beats and shared response
   mem_req_t inst_mem_req;
   mem_req_t data_mem_req;
   mem_req_t bus_req;
   mem_rsp_t bus_rsp;

   cache_ctrl u_inst_cache (
      .clk       (clk),
      .arst_n    (arst_n),
      .req       (inst_req),
      .rsp       (inst_rsp),
      .err       (inst_err),
      .bus_want  (inst_want),
      .bus_grant (inst_grant),
      .mem_req   (inst_mem_req),
      .mem_rsp   (bus_rsp)
   );

   cache_ctrl u_data_cache (
      .clk       (clk),
      .arst_n    (arst_n),
      .req       (data_req),
      .rsp       (data_rsp),
      .err       (data_err),
      .bus_want  (data_want),
      .bus_grant (data_grant),
      .mem_req   (data_mem_req),
      .mem_rsp   (bus_rsp)
   );

   // Side a wins the first tie
   mem_arbiter u_arbiter (
      .clk     (clk),
      .arst_n  (arst_n),
      .want_a  (data_want),
      .want_b  (inst_want),
      .grant_a (data_grant),
      .grant_b (inst_grant),
      .req_a   (data_mem_req),
      .req_b   (inst_mem_req),
      .bus_req (bus_req)
   );

   banked_mem u_mem (
      .clk    (clk),
      .arst_n (arst_n),
      .req    (bus_req),
      .rsp    (bus_rsp)
   );

   assign err = inst_err | data_err;

endmodule

`default_nettype wire

/* hw/mem_system_consts.svh */
// Memory system geometry constants
`ifndef MEM_SYSTEM_CONSTS_SVH
`define MEM_SYSTEM_CONSTS_SVH

// Byte address and word width
`define MS_ADDR_W 16
`define MS_DATA_W 16

// Address split, tag | index | offset
`define MS_TAG_W 5
`define MS_INDEX_W 8
`define MS_OFFSET_W 3

// Words per cache line, also the number of memory banks
`define MS_LINE_WORDS 4

// Cycles from a read beat to its response
`define MS_MEM_LAT 2

`endif

/* mem_system.f */
+incdir+hw
hw/cache_pkg.sv
hw/mem_pkg.sv
hw/cache_array.sv
hw/cache_ctrl.sv
hw/mem_arbiter.sv
hw/banked_mem.sv
hw/mem_system.sv
verif/tb_clkgen.sv
verif/tb_mem_system.sv

/* verif/tb_clkgen.sv */
// Testbench clock and reset
`default_nettype none
`timescale 1ns/1ps

module tb_clkgen (
   output logic clk,
   output logic arst_n
);

   // 40 ns period
   localparam int HALF_PERIOD_NS = 20;
   localparam int RESET_CYCLES   = 10;

   initial begin
      clk = 1'b0;
      forever #(HALF_PERIOD_NS) clk = ~clk;
   end

   // Reset held low, released on a rising edge
   initial begin
      arst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      arst_n <= 1'b1;
   end

endmodule

`default_nettype wire

/* verif/tb_mem_system.sv */
// Two-port memory system testbench
`default_nettype none
`timescale 1ns/1ps

`include "mem_system_consts.svh"

module tb_mem_system
   import cache_pkg::*;
();

   localparam int NUM_PORTS       = 2;
   localparam int DATA_PORT       = 0;
   localparam int INST_PORT       = 1;
   localparam int NUM_RANDOM_OPS  = 400;
   localparam int CYCLES_PER_OP   = 30;
   localparam int WATCHDOG_CYCLES = NUM_RANDOM_OPS * CYCLES_PER_OP;
   localparam int NUM_WORDS       = 2**(`MS_ADDR_W-1);
   localparam int NUM_LINES       = 2**`MS_INDEX_W;

   logic     clk;
   logic     arst_n;
   cpu_req_t inst_req;
   cpu_req_t data_req;
   cpu_rsp_t inst_rsp;
   cpu_rsp_t data_rsp;
   logic     err;

   // Port view, index 0 is data, 1 is instruction
   cpu_req_t req_v [NUM_PORTS];
   cpu_rsp_t rsp_v [NUM_PORTS];

   // Expected response of the access in flight
   word_t exp_rdata   [NUM_PORTS];
   logic  exp_rd      [NUM_PORTS];
   logic  exp_hit     [NUM_PORTS];
   logic  outstanding [NUM_PORTS];
   logic  started;

   // Strobe classes, seen by the checks
   logic [NUM_PORTS-1:0] strobe_ok;
   logic [NUM_PORTS-1:0] bad_strobe;

   // Reference word memory and per-port tag model
   word_t ref_mem [NUM_WORDS];
   bit    known_w [NUM_WORDS];
   bit    vld_m   [NUM_PORTS][NUM_LINES];
   tag_t  tag_m   [NUM_PORTS][NUM_LINES];

   tb_clkgen u_clkgen (
      .clk    (clk),
      .arst_n (arst_n)
   );

   mem_system dut (
      .clk      (clk),
      .arst_n   (arst_n),
      .inst_req (inst_req),
      .data_req (data_req),
      .inst_rsp (inst_rsp),
      .data_rsp (data_rsp),
      .err      (err)
   );

   assign data_req = req_v[DATA_PORT];
   assign inst_req = req_v[INST_PORT];
   assign rsp_v[DATA_PORT] = data_rsp;
   assign rsp_v[INST_PORT] = inst_rsp;

   task automatic stop_on_error(input string line);
      $display("%s", line);
      $display("TEST FAIL");
      $fatal(1, "simulation stopped on first error");
   endtask

   //////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////

   for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port_chk
      assign strobe_ok[p]  = (req_v[p].rd ^ req_v[p].wr) && !rsp_v[p].stall;
      assign bad_strobe[p] = (req_v[p].rd && req_v[p].wr)
                             || ((req_v[p].rd || req_v[p].wr) && rsp_v[p].stall);

      // Nothing moves before the first strobe
      quiet_chk: assert property (@(posedge clk) disable iff (!arst_n)
         !started |-> !rsp_v[p].done && !rsp_v[p].stall && !rsp_v[p].hit && !err)
         else stop_on_error($sformatf("CHECK FAILED at %0t: port %0d active before traffic",
                                      $time, p));

      stall_chk: assert property (@(posedge clk) disable iff (!arst_n)
         strobe_ok[p] |=> rsp_v[p].stall)
         else stop_on_error($sformatf("CHECK FAILED at %0t: port %0d no stall after strobe",
                                      $time, p));

      // Hit answers in exactly two cycles
      hit_lat_chk: assert property (@(posedge clk) disable iff (!arst_n)
         strobe_ok[p] && exp_hit[p] |-> ##2 rsp_v[p].done)
         else stop_on_error($sformatf("CHECK FAILED at %0t: port %0d hit done not at +2",
                                      $time, p));

      done_pulse_chk: assert property (@(posedge clk) disable iff (!arst_n)
         rsp_v[p].done |-> rsp_v[p].stall ##1 !rsp_v[p].done && !rsp_v[p].stall)
         else stop_on_error($sformatf("CHECK FAILED at %0t: port %0d done/stall shape",
                                      $time, p));

      // Each done belongs to an accepted access
      done_owned_chk: assert property (@(posedge clk) disable iff (!arst_n)
         rsp_v[p].done |-> outstanding[p])
         else stop_on_error($sformatf("CHECK FAILED at %0t: port %0d done with no access",
                                      $time, p));

      hit_flag_chk: assert property (@(posedge clk) disable iff (!arst_n)
         rsp_v[p].done |-> rsp_v[p].hit == exp_hit[p])
         else stop_on_error($sformatf("CHECK FAILED at %0t: port %0d hit flag %0b exp %0b",
                                      $time, p, rsp_v[p].hit, exp_hit[p]));

      rdata_chk: assert property (@(posedge clk) disable iff (!arst_n)
         rsp_v[p].done && exp_rd[p] |-> rsp_v[p].rdata == exp_rdata[p])
         else stop_on_error($sformatf("CHECK FAILED at %0t: port %0d rdata %h exp %h",
                                      $time, p, rsp_v[p].rdata, exp_rdata[p]));

      err_chk: assert property (@(posedge clk) disable iff (!arst_n)
         bad_strobe[p] |=> err)
         else stop_on_error($sformatf("CHECK FAILED at %0t: port %0d bad strobe, no err",
                                      $time, p));
   end

   err_cause_chk: assert property (@(posedge clk) disable iff (!arst_n)
      err |-> $past(|bad_strobe))
      else stop_on_error($sformatf("CHECK FAILED at %0t: err without bad strobe", $time));

   //////////////////////////////////////////////////
   // Stimulus helpers
   //////////////////////////////////////////////////

   function automatic logic [`MS_ADDR_W-1:0] make_addr(input tag_t tag, input index_t index,
                                                      input word_sel_t word);
      return {tag, index, word, 1'b0};
   endfunction

   // Small window of tags and lines, so hits and conflicts both happen
   function automatic logic [`MS_ADDR_W-1:0] random_addr(input int port);
      tag_t      tag;
      index_t    index;
      word_sel_t word;
      tag   = {port == INST_PORT, 4'($urandom_range(2))};
      index = index_t'($urandom_range(19, 16));
      word  = word_sel_t'($urandom);
      return make_addr(tag, index, word);
   endfunction

   // One access, expectations set with the strobe, models updated after done
   task automatic access(input int port, input bit wr, input logic [`MS_ADDR_W-1:0] addr,
                         input word_t wdata);
      int     w;
      index_t index;
      tag_t   tag;
      w     = addr[`MS_ADDR_W-1:1];
      index = addr[`MS_OFFSET_W +: `MS_INDEX_W];
      tag   = addr[`MS_ADDR_W-1 -: `MS_TAG_W];
      @(posedge clk);
      req_v[port]       <= '{rd: !wr, wr: wr, addr: addr, wdata: wdata};
      exp_rd[port]      <= !wr;
      exp_hit[port]     <= vld_m[port][index] && (tag_m[port][index] == tag);
      exp_rdata[port]   <= ref_mem[w];
      outstanding[port] <= 1'b1;
      started           <= 1'b1;
      if (wr) begin
         ref_mem[w] = wdata;
         known_w[w] = 1'b1;
      end
      @(posedge clk);
      req_v[port] <= '0;
      // Mid-cycle sampling
      @(negedge clk);
      while (!rsp_v[port].done) @(negedge clk);
      @(posedge clk);
      outstanding[port]  <= 1'b0;
      vld_m[port][index] = 1'b1;
      tag_m[port][index] = tag;
   endtask

   task automatic both_strobe(input int port, input logic [`MS_ADDR_W-1:0] addr);
      @(posedge clk);
      req_v[port] <= '{rd: 1'b1, wr: 1'b1, addr: addr, wdata: 16'hdead};
      started     <= 1'b1;
      @(posedge clk);
      req_v[port] <= '0;
      repeat (4) @(posedge clk);
   endtask

   // Second strobe once the port is stalled
   task automatic strobe_while_busy(input int port, input logic [`MS_ADDR_W-1:0] addr);
      @(negedge clk);
      while (!rsp_v[port].stall) @(negedge clk);
      @(posedge clk);
      req_v[port] <= '{rd: 1'b1, wr: 1'b0, addr: addr, wdata: '0};
      @(posedge clk);
      req_v[port] <= '0;
   endtask

   task automatic random_ops(input int port, input int count);
      logic [`MS_ADDR_W-1:0] addr;
      bit                    wr;
      for (int i = 0; i < count; i++) begin
         addr = random_addr(port);
         // Never read a word that memory has not seen
         wr = ($urandom_range(1) == 1) || !known_w[addr[`MS_ADDR_W-1:1]];
         access(port, wr, addr, word_t'($urandom));
      end
   endtask

   //////////////////////////////////////////////////
   // Run control
   //////////////////////////////////////////////////

   initial begin
      wait (arst_n === 1'b1);
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      stop_on_error("Watchdog expired, the tests did not finish in time");
   end

   initial begin
      logic [`MS_ADDR_W-1:0] addr_a;
      logic [`MS_ADDR_W-1:0] addr_b;
      void'($urandom(9724));
      for (int p = 0; p < NUM_PORTS; p++) begin
         req_v[p]       <= '0;
         exp_rd[p]      <= 1'b0;
         exp_hit[p]     <= 1'b0;
         exp_rdata[p]   <= '0;
         outstanding[p] <= 1'b0;
      end
      started <= 1'b0;
      wait (arst_n === 1'b1);
      // Idle window after reset
      repeat (5) @(posedge clk);

      // Write miss then read hit
      addr_a = make_addr(5'd1, 8'd5, 2'd2);
      access(DATA_PORT, 1'b1, addr_a, 16'h1234);
      access(DATA_PORT, 1'b0, addr_a, '0);

      // Same index, other tag, then back to A
      addr_a = make_addr(5'd2, 8'd9, 2'd1);
      addr_b = make_addr(5'd3, 8'd9, 2'd1);
      access(DATA_PORT, 1'b1, addr_a, 16'h5a5a);
      access(DATA_PORT, 1'b1, addr_b, 16'ha5a5);
      access(DATA_PORT, 1'b0, addr_a, '0);

      // Simultaneous misses, dirty victims on both sides
      fork
         access(DATA_PORT, 1'b1, make_addr(5'd4, 8'd12, 2'd3), 16'h0c03);
         access(INST_PORT, 1'b1, make_addr(5'd20, 8'd12, 2'd3), 16'h8c03);
      join
      fork
         access(DATA_PORT, 1'b1, make_addr(5'd5, 8'd12, 2'd0), 16'h0d00);
         access(INST_PORT, 1'b1, make_addr(5'd21, 8'd12, 2'd0), 16'h8d00);
      join
      fork
         access(DATA_PORT, 1'b0, make_addr(5'd4, 8'd12, 2'd3), '0);
         access(INST_PORT, 1'b0, make_addr(5'd20, 8'd12, 2'd3), '0);
      join

      // Error strobes
      both_strobe(INST_PORT, make_addr(5'd22, 8'd40, 2'd0));
      fork
         access(DATA_PORT, 1'b1, make_addr(5'd6, 8'd30, 2'd0), 16'h1e00);
         strobe_while_busy(DATA_PORT, make_addr(5'd6, 8'd31, 2'd0));
      join

      // Random traffic on both ports at once
      fork
         random_ops(DATA_PORT, NUM_RANDOM_OPS / 2);
         random_ops(INST_PORT, NUM_RANDOM_OPS / 2);
      join
      repeat (5) @(posedge clk);
      $display("TEST PASS");
      $finish;
   end

endmodule

`default_nettype wire
